// File: vlog.f
+incdir+src
src/mmc5_pkg.sv
src/mmc5_regs.sv
src/prg_bank_map.sv
src/chr_bank_map.sv
src/scanline_irq.sv
src/exram.sv
src/mmc5_top.sv
verification/tb_mmc5.sv

// File: Bender.yml
package:
  name: mmc5_mapper

sources:
  - include_dirs:
      - src
    files:
      - src/mmc5_pkg.sv
      - src/mmc5_regs.sv
      - src/prg_bank_map.sv
      - src/chr_bank_map.sv
      - src/scanline_irq.sv
      - src/exram.sv
      - src/mmc5_top.sv
      - target: test
        files:
          - verification/tb_mmc5.sv

// File: verification/tb_mmc5.sv
// Mapper testbench
`timescale 1ns/1ns
`include "mmc5_config.svh"

module tb_mmc5;

	localparam int max_cycles = 2000;   // Whole sequence runs in a few hundred cycles

	logic clk = 0, rst = 1, ce = 1, prg_read = 0, prg_write = 0;
	logic ppu_ce = 1, ppu_in_frame = 0, ppu_sprite16 = 0;
	mmc5_pkg::cpu_addr_t  prg_ain = '0;
	mmc5_pkg::cpu_data_t  prg_din = '0;
	mmc5_pkg::ppu_addr_t  chr_ain = '0;
	mmc5_pkg::ppu_count_t ppu_cycle = '0, ppu_scanline = '0;
	mmc5_pkg::cpu_data_t  prg_dout;
	mmc5_pkg::map_addr_t  prg_aout, chr_aout;
	logic                 prg_allow, vram_a10, vram_ce, irq;

	integer seed = 32'h1c450426;
	int errors = 0, test_errors = 0, tests = 0, failed_tests = 0, cycles = 0;
	logic [7:0] prg_model [4];    // Expected PRG bank registers
	logic [2:0] ram_bank_model;
	logic [9:0] chr_model [12];   // Expected CHR banks, upper bits included

	mmc5_top i_mmc5_top (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > max_cycles) begin
			$display("Timeout, run did not finish within %0d cycles", max_cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;   // Drive point after the edge
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic cpu_write(input mmc5_pkg::cpu_addr_t a, input mmc5_pkg::cpu_data_t d);
		prg_ain   = a;
		prg_din   = d;
		prg_write = 1;
		next_cycle();
		prg_write = 0;
	endtask

	// Address held two cycles, strobe only in the sampled one
	task automatic cpu_read(input mmc5_pkg::cpu_addr_t a, output mmc5_pkg::cpu_data_t d);
		prg_ain = a;
		next_cycle();
		prg_read = 1;
		@(negedge clk);
		d = prg_dout;
		next_cycle();
		prg_read = 0;
	endtask

	task automatic scan_step(input int line);
		ppu_scanline = 9'(line);
		next_cycle();
	endtask

	task automatic check_allow(input mmc5_pkg::cpu_addr_t a, input logic wr, input logic exp);
		prg_ain   = a;
		prg_write = wr;
		@(negedge clk);
		check_value("prg_allow", prg_allow, exp);
		next_cycle();
		prg_write = 0;
	endtask

	task automatic check_irq(input logic exp);
		@(negedge clk);
		check_value("irq", irq, exp);
		next_cycle();
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != test_errors)
			failed_tests++;
		$display("Test %0d %s: %s", tests, name, (errors == test_errors) ? "ok" : "failed");
		test_errors = errors;
	endtask

	// PRG bank table, bit 7 of the selection marks ROM
	function automatic mmc5_pkg::map_addr_t exp_prg_addr(input logic [1:0] mode,
		input mmc5_pkg::cpu_addr_t a);
		logic [7:0] bank;
		logic [1:0] slot;
		slot = a[14:13];
		if (a < 16'h8000)
			bank = {5'b00000, ram_bank_model};
		else case (mode)
			2'd0:    bank = {1'b1, prg_model[3][6:2], slot};
			2'd1:    bank = slot[1] ? {1'b1, prg_model[3][6:1], slot[0]}
				: {prg_model[1][7:1], slot[0]};
			2'd2:    bank = !slot[1] ? {prg_model[1][7:1], slot[0]}
				: (slot[0] ? {1'b1, prg_model[3][6:0]} : prg_model[2]);
			default: bank = (slot == 2'd3) ? {1'b1, prg_model[3][6:0]} : prg_model[slot];
		endcase
		if (bank[7])
			return {2'b00, bank[6:0], a[12:0]};
		return {`MMC5_PRG_RAM_HIGH, bank[2:0], a[12:0]};
	endfunction

	// Only the 4 KB and 1 KB modes are exercised
	function automatic mmc5_pkg::map_addr_t exp_chr_addr(input logic [1:0] mode,
		input mmc5_pkg::ppu_addr_t a, input logic set);
		logic [3:0] idx;
		logic [9:0] page;
		if (mode == 2'd1) begin
			idx  = set ? 4'd11 : (a[12] ? 4'd7 : 4'd3);
			page = {chr_model[idx][7:0], a[11:10]};
		end else begin
			idx  = set ? {2'b10, a[11:10]} : {1'b0, a[12:10]};   // Set B repeats per 4 KB
			page = chr_model[idx];
		end
		return {`MMC5_CHR_HIGH, page, a[9:0]};
	endfunction

	task automatic check_prg_slots(input logic [1:0] mode);
		for (int s = 0; s < 5; s++) begin
			prg_ain = 16'h6000 + 16'(s * 'h2000) + 16'($random(seed) & 'h1FFF);
			@(negedge clk);
			check_value("prg_aout", prg_aout, exp_prg_addr(mode, prg_ain));
			next_cycle();
		end
	endtask

	task automatic check_chr_slots(input logic [1:0] mode, input logic set);
		for (int s = 0; s < 8; s++) begin
			chr_ain = {1'b0, 3'(s), 10'($random(seed))};
			@(negedge clk);
			check_value("chr_aout", chr_aout, exp_chr_addr(mode, chr_ain, set));
			check_value("vram_ce", vram_ce, 0);   // Pattern fetch, no VRAM
			next_cycle();
		end
	endtask

	initial begin
		mmc5_pkg::cpu_data_t a, b, d, lo, hi, m;
		mmc5_pkg::cpu_addr_t ex_addr;
		repeat (3) @(posedge clk);
		#2;
		rst = 0;

		prg_ain = 16'hE000;   // Reset vector slot
		@(negedge clk);
		check_value("prg_aout", prg_aout, {2'b00, 7'h7F, 13'h0000});
		next_cycle();
		ram_bank_model = 3'($random(seed));
		cpu_write(16'h5113, {5'b00000, ram_bank_model});
		for (int mode = 0; mode < 4; mode++) begin
			cpu_write(16'h5100, 8'(mode));
			for (int i = 0; i < 4; i++) begin
				prg_model[i] = 8'($random(seed));
				cpu_write(16'h5114 + 16'(i), prg_model[i]);
			end
			check_prg_slots(2'(mode));
		end
		end_test("prg banking");

		check_allow(`MMC5_PRG_RAM_START, 1, 0);
		cpu_write(16'h5102, 8'h02);
		check_allow(`MMC5_PRG_RAM_START, 1, 0);   // One key alone is not enough
		cpu_write(16'h5103, 8'h01);
		check_allow(`MMC5_PRG_RAM_START, 1, 1);
		check_allow(16'h8000, 0, 1);
		check_allow(16'h4000, 0, 0);              // Below the cart window
		check_allow(16'hE000, 1, 0);              // ROM slot
		end_test("prg ram protect");

		cpu_write(16'h5101, 8'h03);
		m = (8'($random(seed)) & 8'h03) | 8'h01;   // Upper bits never both 0
		cpu_write(16'h5130, m);
		for (int i = 0; i < 12; i++) begin
			chr_model[i] = {m[1:0], 8'($random(seed))};
			cpu_write(16'h5120 + 16'(i), chr_model[i][7:0]);
		end
		check_chr_slots(2'd3, 1);   // $512B went last
		cpu_write(16'h5120, chr_model[0][7:0]);
		check_chr_slots(2'd3, 0);
		cpu_write(16'h5101, 8'h01);
		check_chr_slots(2'd1, 0);
		cpu_write(16'h5128, chr_model[8][7:0]);
		check_chr_slots(2'd1, 1);
		ppu_sprite16 = 1;
		ppu_in_frame = 1;
		ppu_cycle    = 9'd260;      // Sprite fetch
		check_chr_slots(2'd1, 0);
		cpu_write(16'h5120, chr_model[0][7:0]);
		ppu_cycle    = 9'd100;      // Background fetch
		check_chr_slots(2'd1, 1);
		ppu_sprite16 = 0;
		ppu_in_frame = 0;
		m = 8'($random(seed));
		cpu_write(16'h5105, m);
		for (int q = 0; q < 4; q++) begin
			chr_ain = 14'h2000 + 14'(q * 'h400) + 14'($random(seed) & 'h3FF);
			@(negedge clk);
			check_value("vram_a10", vram_a10, m[2 * q]);
			check_value("vram_ce", vram_ce, !m[2 * q + 1]);
			next_cycle();
		end
		end_test("chr banking and mirroring");

		for (int i = 0; i < 4; i++) begin
			a = 8'($random(seed));
			b = 8'($random(seed));
			cpu_write(`MMC5_MUL_LO_ADDR, a);
			cpu_write(`MMC5_MUL_HI_ADDR, b);
			cpu_read(`MMC5_MUL_LO_ADDR, lo);
			cpu_read(`MMC5_MUL_HI_ADDR, hi);
			check_value("product", {hi, lo}, 16'(a) * 16'(b));
		end
		end_test("multiplier");

		ex_addr = {6'b010111, 10'($random(seed))};
		d = (8'($random(seed)) & 8'h7F) | 8'h01;   // Neither d nor ~d is 0, so a stored 0 is seen
		cpu_write(16'h5104, 8'h02);
		cpu_write(ex_addr, d);
		cpu_read(ex_addr, b);
		check_value("prg_dout", b, d);
		cpu_write(16'h5104, 8'h03);
		cpu_write(ex_addr, ~d);          // Dropped, read-only mode
		cpu_read(ex_addr, b);
		check_value("prg_dout", b, d);
		cpu_write(16'h5104, 8'h00);
		cpu_read(ex_addr, b);
		check_value("prg_dout", b, 8'hFF);
		cpu_write(ex_addr, ~d);          // Out of frame
		cpu_write(16'h5104, 8'h02);
		cpu_read(ex_addr, b);
		check_value("prg_dout", b, 8'h00);
		end_test("expansion ram");

		cpu_write(16'h5203, 8'd20);
		cpu_write(`MMC5_STATUS_ADDR, 8'h80);
		scan_step(19);
		scan_step(20);
		scan_step(21);
		check_irq(1);
		cpu_read(`MMC5_STATUS_ADDR, d);
		check_value("status[7]", d[7], 1);
		check_irq(0);                    // Status read acknowledged it
		cpu_read(`MMC5_STATUS_ADDR, d);
		check_value("status[7]", d[7], 0);
		cpu_write(`MMC5_STATUS_ADDR, 8'h00);
		scan_step(20);
		scan_step(21);
		check_irq(0);
		cpu_read(`MMC5_STATUS_ADDR, d);
		check_value("status[7]", d[7], 1);
		end_test("scanline irq");

		$display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: src/mmc5_top.sv
// Mapper top level
`timescale 1ns/1ns
`include "mmc5_config.svh"

module mmc5_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ce,
	input  logic                 prg_read,
	input  logic                 prg_write,
	input  logic                 ppu_ce,
	input  logic                 ppu_in_frame,
	input  logic                 ppu_sprite16,
	input  mmc5_pkg::cpu_addr_t  prg_ain,
	input  mmc5_pkg::cpu_data_t  prg_din,
	input  mmc5_pkg::ppu_addr_t  chr_ain,
	input  mmc5_pkg::ppu_count_t ppu_cycle,
	input  mmc5_pkg::ppu_count_t ppu_scanline,
	output mmc5_pkg::cpu_data_t  prg_dout,
	output mmc5_pkg::map_addr_t  prg_aout,
	output mmc5_pkg::map_addr_t  chr_aout,
	output logic                 prg_allow,
	output logic                 vram_a10,
	output logic                 vram_ce,
	output logic                 irq
);

	mmc5_pkg::bank_mode_t prg_mode, chr_mode, exram_mode;
	logic [2:0]           prg_ram_bank;
	mmc5_pkg::prg_bank_t  prg_banks [4];
	mmc5_pkg::chr_bank_t  chr_banks [`MMC5_NUM_CHR_BANKS];
	logic                 chr_last;
	mmc5_pkg::cpu_data_t  mirroring;
	logic                 ram_write_ok;
	mmc5_pkg::cpu_data_t  irq_line;
	logic                 irq_enable, irq_ack, irq_pending;
	mmc5_pkg::cpu_data_t  exram_rdata;

	mmc5_regs i_mmc5_regs (
		.clk, .rst, .ce, .prg_read, .prg_write, .prg_ain, .prg_din,
		.ppu_in_frame, .irq_pending, .exram_rdata, .prg_dout,
		.prg_mode, .chr_mode, .exram_mode, .prg_ram_bank, .prg_banks, .chr_banks,
		.chr_upper (),   // Already folded into each CHR bank on write
		.chr_last, .mirroring, .ram_write_ok, .irq_line, .irq_enable, .irq_ack
	);

	prg_bank_map i_prg_bank_map (
		.prg_ain, .prg_write, .prg_mode, .prg_ram_bank, .prg_banks, .ram_write_ok,
		.prg_aout, .prg_allow
	);

	chr_bank_map i_chr_bank_map (
		.chr_ain, .chr_mode, .chr_banks, .chr_last, .mirroring,
		.ppu_in_frame, .ppu_sprite16, .ppu_cycle,
		.chr_aout, .vram_a10, .vram_ce
	);

	scanline_irq i_scanline_irq (
		.clk, .rst, .ppu_ce, .ppu_scanline, .irq_line, .irq_enable, .irq_ack,
		.irq_pending, .irq
	);

	exram i_exram (
		.clk, .ce, .prg_write, .prg_ain, .prg_din, .exram_mode, .ppu_in_frame,
		.exram_rdata
	);

endmodule

// File: src/exram.sv
// Expansion RAM
`timescale 1ns/1ns
`include "mmc5_config.svh"

module exram (
	input  logic                 clk,
	input  logic                 ce,
	input  logic                 prg_write,
	input  mmc5_pkg::cpu_addr_t  prg_ain,
	input  mmc5_pkg::cpu_data_t  prg_din,
	input  mmc5_pkg::bank_mode_t exram_mode,
	input  logic                 ppu_in_frame,
	output mmc5_pkg::cpu_data_t  exram_rdata
);

	mmc5_pkg::cpu_data_t mem [`MMC5_EXRAM_DEPTH];   // Block RAM
	mmc5_pkg::exram_addr_t addr;
	logic                  in_window;

	assign addr      = prg_ain[9:0];
	assign in_window = (prg_ain[15:10] == `MMC5_EXRAM_BASE);   // $5C00-$5FFF

	// Mode 3 is read-only
	// Modes 0/1 only take data while rendering, else a zero lands
	always_ff @(posedge clk) begin
		if (ce && prg_write && in_window && (exram_mode != 2'd3))
			mem[addr] <= (exram_mode[1] || ppu_in_frame) ? prg_din : '0;
		exram_rdata <= mem[addr];   // One clock behind the address
	end

endmodule

// File: src/scanline_irq.sv
// Scanline IRQ
`timescale 1ns/1ns
`include "mmc5_config.svh"

module scanline_irq (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ppu_ce,
	input  mmc5_pkg::ppu_count_t ppu_scanline,
	input  mmc5_pkg::cpu_data_t  irq_line,
	input  logic                 irq_enable,
	input  logic                 irq_ack,
	output logic                 irq_pending,
	output logic                 irq
);

	logic irq_trig;       // Current line matches the compare value
	logic last_parity;    // Scanline bit 0 seen on the previous ppu_ce

	always_ff @(posedge clk) begin
		if (rst) begin
			irq_trig    <= 1'b0;
			last_parity <= 1'b0;
			irq_pending <= 1'b0;
		end else begin
			if (ppu_ce) begin
				irq_trig    <= (irq_line != 8'd0) && (irq_line < `MMC5_IRQ_LAST_LINE) &&
					(ppu_scanline == {1'b0, irq_line});
				last_parity <= ppu_scanline[0];
			end
			// Fires when the matched line ends
			if (irq_ack)
				irq_pending <= 1'b0;
			else if (ppu_ce && irq_trig && (ppu_scanline[0] != last_parity))
				irq_pending <= 1'b1;
		end
	end

	assign irq = irq_pending && irq_enable;

endmodule

// File: src/chr_bank_map.sv
// CHR address and nametable mapping
`timescale 1ns/1ns
`include "mmc5_config.svh"

module chr_bank_map (
	input  mmc5_pkg::ppu_addr_t  chr_ain,
	input  mmc5_pkg::bank_mode_t chr_mode,
	input  mmc5_pkg::chr_bank_t  chr_banks [`MMC5_NUM_CHR_BANKS],
	input  logic                 chr_last,
	input  mmc5_pkg::cpu_data_t  mirroring,
	input  logic                 ppu_in_frame,
	input  logic                 ppu_sprite16,
	input  mmc5_pkg::ppu_count_t ppu_cycle,
	output mmc5_pkg::map_addr_t  chr_aout,
	output logic                 vram_a10,
	output logic                 vram_ce
);

	logic                is_bg_fetch;
	logic                chr_set;      // 0 = $5120-$5127, 1 = $5128-$512B
	mmc5_pkg::chr_bank_t chr_sel;      // 1 KB page number
	logic [1:0]          mirr_bits;

	// Sprite patterns are fetched on cycles 256-319
	assign is_bg_fetch = !(ppu_cycle[8] && !ppu_cycle[6]);
	assign chr_set     = (ppu_sprite16 && ppu_in_frame) ? is_bg_fetch : chr_last;

	always_comb begin
		casez ({chr_mode, chr_ain[12:10], chr_set})
			6'b00_???_0: chr_sel = {chr_banks[7][6:0], chr_ain[12:10]};   // 8 KB
			6'b00_???_1: chr_sel = {chr_banks[11][6:0], chr_ain[12:10]};
			6'b01_0??_0: chr_sel = {chr_banks[3][7:0], chr_ain[11:10]};   // 4 KB
			6'b01_1??_0: chr_sel = {chr_banks[7][7:0], chr_ain[11:10]};
			6'b01_???_1: chr_sel = {chr_banks[11][7:0], chr_ain[11:10]};
			6'b10_00?_0: chr_sel = {chr_banks[1][8:0], chr_ain[10]};      // 2 KB
			6'b10_01?_0: chr_sel = {chr_banks[3][8:0], chr_ain[10]};
			6'b10_10?_0: chr_sel = {chr_banks[5][8:0], chr_ain[10]};
			6'b10_11?_0: chr_sel = {chr_banks[7][8:0], chr_ain[10]};
			6'b10_?0?_1: chr_sel = {chr_banks[9][8:0], chr_ain[10]};
			6'b10_?1?_1: chr_sel = {chr_banks[11][8:0], chr_ain[10]};
			6'b11_???_0: chr_sel = chr_banks[chr_ain[12:10]];             // 1 KB, eight slots
			default:     chr_sel = chr_banks[{2'b10, chr_ain[11:10]}];    // Set B repeats per 4 KB
		endcase
	end

	assign chr_aout = {`MMC5_CHR_HIGH, chr_sel, chr_ain[9:0]};

	// Quadrant field, 00 = VRAM page A, 01 = page B, 1x = not internal VRAM
	assign mirr_bits = mirroring[{chr_ain[11:10], 1'b0} +: 2];
	assign vram_a10  = mirr_bits[0];
	assign vram_ce   = chr_ain[13] && !mirr_bits[1];

endmodule

// File: src/prg_bank_map.sv
// PRG address mapping
`timescale 1ns/1ns
`include "mmc5_config.svh"

module prg_bank_map (
	input  mmc5_pkg::cpu_addr_t  prg_ain,
	input  logic                 prg_write,
	input  mmc5_pkg::bank_mode_t prg_mode,
	input  logic [2:0]           prg_ram_bank,
	input  mmc5_pkg::prg_bank_t  prg_banks [4],
	input  logic                 ram_write_ok,
	output mmc5_pkg::map_addr_t  prg_aout,
	output logic                 prg_allow
);

	mmc5_pkg::prg_bank_t prg_sel;   // Bit 7 set means ROM

	always_comb begin
		casez ({prg_mode, prg_ain[15:13]})
			5'b00_1??: prg_sel = {1'b1, prg_banks[3][6:2], prg_ain[14:13]};  // 32 KB
			5'b01_10?: prg_sel = {prg_banks[1][7:1], prg_ain[13]};           // 16 KB low
			5'b01_11?: prg_sel = {1'b1, prg_banks[3][6:1], prg_ain[13]};     // 16 KB high
			5'b10_10?: prg_sel = {prg_banks[1][7:1], prg_ain[13]};
			5'b10_110: prg_sel = prg_banks[2];
			5'b10_111: prg_sel = {1'b1, prg_banks[3][6:0]};
			5'b11_100: prg_sel = prg_banks[0];                               // 8 KB slots
			5'b11_101: prg_sel = prg_banks[1];
			5'b11_110: prg_sel = prg_banks[2];
			5'b11_111: prg_sel = {1'b1, prg_banks[3][6:0]};
			default:   prg_sel = {5'b00000, prg_ram_bank};                   // $6000-$7FFF RAM
		endcase
	end

	// 8 KB pages, ROM banks at the bottom and RAM at the fixed top
	assign prg_aout = {prg_sel[7] ? {2'b00, prg_sel[6:0]} : {`MMC5_PRG_RAM_HIGH, prg_sel[2:0]},
		prg_ain[12:0]};

	assign prg_allow = (prg_ain >= `MMC5_PRG_RAM_START) &&
		(!prg_write || (!prg_sel[7] && ram_write_ok));

endmodule

// File: src/mmc5_regs.sv
// Mapper register block
`timescale 1ns/1ns
`include "mmc5_config.svh"

module mmc5_regs (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ce,
	input  logic                  prg_read,
	input  logic                  prg_write,
	input  mmc5_pkg::cpu_addr_t   prg_ain,
	input  mmc5_pkg::cpu_data_t   prg_din,
	input  logic                  ppu_in_frame,
	input  logic                  irq_pending,
	input  mmc5_pkg::cpu_data_t   exram_rdata,
	output mmc5_pkg::cpu_data_t   prg_dout,
	output mmc5_pkg::bank_mode_t  prg_mode,
	output mmc5_pkg::bank_mode_t  chr_mode,
	output mmc5_pkg::bank_mode_t  exram_mode,
	output logic [2:0]            prg_ram_bank,
	output mmc5_pkg::prg_bank_t   prg_banks [4],
	output mmc5_pkg::chr_bank_t   chr_banks [`MMC5_NUM_CHR_BANKS],
	output logic [1:0]            chr_upper,
	output logic                  chr_last,     // Set written last, 1 = $5128 set
	output mmc5_pkg::cpu_data_t   mirroring,    // Two bits per nametable quadrant
	output logic                  ram_write_ok,
	output mmc5_pkg::cpu_data_t   irq_line,
	output logic                  irq_enable,
	output logic                  irq_ack
);

	logic [1:0]          protect_1;   // Raw key bits from $5102
	logic [1:0]          protect_2;   // Raw key bits from $5103
	mmc5_pkg::cpu_data_t mul_a;
	mmc5_pkg::cpu_data_t mul_b;
	logic [15:0]         product;

	wire reg_wr = ce && prg_write && (prg_ain[15:10] == `MMC5_REG_BASE);

	always_ff @(posedge clk) begin
		if (rst) begin
			prg_mode     <= 2'd3;           // Four 8 KB slots
			chr_mode     <= '0;
			exram_mode   <= '0;
			protect_1    <= '0;
			protect_2    <= '0;
			mirroring    <= '0;
			prg_ram_bank <= '0;
			prg_banks[0] <= '0;
			prg_banks[1] <= '0;
			prg_banks[2] <= '0;
			prg_banks[3] <= '1;             // Reset vector lands in the last bank
			for (int i = 0; i < `MMC5_NUM_CHR_BANKS; i++)
				chr_banks[i] <= '0;
			chr_upper    <= '0;
			chr_last     <= 1'b0;
			irq_line     <= '0;
			irq_enable   <= 1'b0;
			mul_a        <= '0;
			mul_b        <= '0;
		end else if (reg_wr) begin
			case (prg_ain[9:0])
				`MMC5_REG_PRG_MODE:     prg_mode     <= prg_din[1:0];
				`MMC5_REG_CHR_MODE:     chr_mode     <= prg_din[1:0];
				`MMC5_REG_PROTECT_1:    protect_1    <= prg_din[1:0];
				`MMC5_REG_PROTECT_2:    protect_2    <= prg_din[1:0];
				`MMC5_REG_EXRAM_MODE:   exram_mode   <= prg_din[1:0];
				`MMC5_REG_MIRRORING:    mirroring    <= prg_din;
				`MMC5_REG_PRG_RAM_BANK: prg_ram_bank <= prg_din[2:0];
				`MMC5_REG_PRG_BANK_0:   prg_banks[0] <= prg_din;
				`MMC5_REG_PRG_BANK_1:   prg_banks[1] <= prg_din;
				`MMC5_REG_PRG_BANK_2:   prg_banks[2] <= prg_din;
				`MMC5_REG_PRG_BANK_3:   prg_banks[3] <= prg_din;   // Bit 7 unused, always ROM
				`MMC5_REG_CHR_UPPER:    chr_upper    <= prg_din[1:0];
				`MMC5_REG_IRQ_LINE:     irq_line     <= prg_din;
				`MMC5_REG_IRQ_STATUS:   irq_enable   <= prg_din[7];
				`MMC5_REG_MUL_A:        mul_a        <= prg_din;
				`MMC5_REG_MUL_B:        mul_b        <= prg_din;
				default: ;
			endcase

			// $5120-$512F, holes above $512B only mark the set
			if (prg_ain[9:4] == `MMC5_REG_CHR_WIN) begin
				chr_last <= prg_ain[3];
				if (prg_ain[3:0] < `MMC5_NUM_CHR_BANKS)
					chr_banks[prg_ain[3:0]] <= {chr_upper, prg_din};
			end
		end
	end

	assign ram_write_ok = (protect_1 == 2'b10) && (protect_2 == 2'b01);  // Both keys must match
	assign product      = mul_a * mul_b;

	// Reading the status register acknowledges the IRQ
	assign irq_ack = ce && prg_read && (prg_ain == `MMC5_STATUS_ADDR);

	// CPU read mux, anything unmapped is open bus
	always_comb begin
		prg_dout = 8'hFF;
		if (prg_ain[15:10] == `MMC5_EXRAM_BASE && exram_mode[1])
			prg_dout = exram_rdata;
		else if (prg_ain == `MMC5_STATUS_ADDR)
			prg_dout = {irq_pending, ppu_in_frame, 6'b111111};
		else if (prg_ain == `MMC5_MUL_LO_ADDR)
			prg_dout = product[7:0];
		else if (prg_ain == `MMC5_MUL_HI_ADDR)
			prg_dout = product[15:8];
	end

endmodule

// File: src/mmc5_pkg.sv
// Mapper shared types
package mmc5_pkg;

	// CPU side
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;   // Also the expansion RAM byte

	// PPU side
	typedef logic [13:0] ppu_addr_t;
	typedef logic [8:0]  ppu_count_t;  // Cycle or scanline

	// Cart memory address, PRG and CHR alike
	typedef logic [21:0] map_addr_t;

	// Banking
	typedef logic [1:0]  bank_mode_t;
	typedef logic [7:0]  prg_bank_t;
	typedef logic [9:0]  chr_bank_t;   // Two upper bits from $5130 on top

	typedef logic [9:0]  exram_addr_t;

endpackage

// File: src/mmc5_config.svh
// Mapper constants
`ifndef MMC5_CONFIG_SVH
`define MMC5_CONFIG_SVH

`define MMC5_REG_BASE         6'b010100   // $5000-$53FF
`define MMC5_EXRAM_BASE       6'b010111   // $5C00-$5FFF

// Offsets inside the register window
`define MMC5_REG_PRG_MODE     10'h100
`define MMC5_REG_CHR_MODE     10'h101
`define MMC5_REG_PROTECT_1    10'h102
`define MMC5_REG_PROTECT_2    10'h103
`define MMC5_REG_EXRAM_MODE   10'h104
`define MMC5_REG_MIRRORING    10'h105
`define MMC5_REG_PRG_RAM_BANK 10'h113
`define MMC5_REG_PRG_BANK_0   10'h114
`define MMC5_REG_PRG_BANK_1   10'h115
`define MMC5_REG_PRG_BANK_2   10'h116
`define MMC5_REG_PRG_BANK_3   10'h117
`define MMC5_REG_CHR_WIN      6'b010010   // Offset bits [9:4] of $5120-$512F
`define MMC5_REG_CHR_UPPER    10'h130
`define MMC5_REG_IRQ_LINE     10'h203
`define MMC5_REG_IRQ_STATUS   10'h204
`define MMC5_REG_MUL_A        10'h205
`define MMC5_REG_MUL_B        10'h206

`define MMC5_STATUS_ADDR      16'h5204
`define MMC5_MUL_LO_ADDR      16'h5205
`define MMC5_MUL_HI_ADDR      16'h5206
`define MMC5_PRG_RAM_START    16'h6000
`define MMC5_PRG_RAM_HIGH     6'b111100   // Save RAM sits at the top of the map
`define MMC5_CHR_HIGH         2'b10
`define MMC5_IRQ_LAST_LINE    8'd240
`define MMC5_NUM_CHR_BANKS    12
`define MMC5_EXRAM_DEPTH      1024

`endif
